// ==== include/rcu_consts.svh ====
// sizing macros for architectural and physical registers, reorder buffer and pc
`ifndef RCU_CONSTS_SVH
`define RCU_CONSTS_SVH

// architectural register file
`define RCU_ARCH_REGS 32
`define RCU_ARCH_W    5

// physical registers, p0 is the constant zero register
`define RCU_PHYS_REGS 64
`define RCU_PHYS_W    6

// reorder buffer lines
`define RCU_ROB_DEPTH 8
`define RCU_ROB_W     3

`define RCU_PC_W      32

`endif

// ==== logic/rcu_pkg.sv ====
// rcu_pkg with dispatch, rename, issue, writeback and commit struct types
`include "rcu_consts.svh"

package rcu_pkg;

    // one instruction from the front end
    typedef struct packed {
        logic                   valid;
        logic [`RCU_PC_W-1:0]   pc;
        logic [`RCU_ARCH_W-1:0] rs1;
        logic [`RCU_ARCH_W-1:0] rs2;
        logic [`RCU_ARCH_W-1:0] rd;
        logic                   uses_rs1;
        logic                   uses_rs2;
        logic                   uses_rd;
    } dispatch_t;

    // lprd is the mapping of rd before this instruction
    typedef struct packed {
        logic [`RCU_PHYS_W-1:0] prs1;
        logic [`RCU_PHYS_W-1:0] prs2;
        logic [`RCU_PHYS_W-1:0] prd;
        logic [`RCU_PHYS_W-1:0] lprd;
    } renamed_t;

    typedef struct packed {
        logic                   valid;
        logic [`RCU_ROB_W-1:0]  line;
        logic [`RCU_PC_W-1:0]   pc;
        logic [`RCU_PHYS_W-1:0] prs1;
        logic [`RCU_PHYS_W-1:0] prs2;
        logic [`RCU_PHYS_W-1:0] prd;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`RCU_ROB_W-1:0]  line;
        logic [`RCU_PHYS_W-1:0] prd;
    } wb_t;

    typedef struct packed {
        logic                   valid;
        logic [`RCU_PC_W-1:0]   pc;
        logic [`RCU_ARCH_W-1:0] rd;
        logic [`RCU_PHYS_W-1:0] prd;
        logic [`RCU_PHYS_W-1:0] lprd;
    } commit_t;

endpackage

// ==== logic/rename_map.sv ====
// rename_map: rename table, committed map, free bitmap and committed-busy bitmap
`timescale 1ns/10ps
`include "rcu_consts.svh"

module rename_map import rcu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      trapped,
    input  dispatch_t dispatch,
    input  logic      accept,
    input  commit_t   commit,
    output renamed_t  renamed,
    output logic      free_empty
);

    // speculative map, updated at dispatch
    logic [`RCU_PHYS_W-1:0] spec_map [`RCU_ARCH_REGS];
    // committed map, updated at retire, source of the flush copy
    logic [`RCU_PHYS_W-1:0] comm_map [`RCU_ARCH_REGS];

    // one bit per physical register
    logic [`RCU_PHYS_REGS-1:0] free_bits;
    logic [`RCU_PHYS_REGS-1:0] comm_busy;

    logic [`RCU_PHYS_W-1:0] free_pick;
    logic                   has_rd;

    // priority scan, the lowest free register wins
    always_comb begin
        free_pick = '0;
        for (int i = `RCU_PHYS_REGS - 1; i > 0; i--) begin
            if (free_bits[i]) begin
                free_pick = i[`RCU_PHYS_W-1:0];
            end
        end
    end

    assign free_empty = ~|free_bits;

    // x0 as destination never takes a register
    assign has_rd = dispatch.uses_rd && (dispatch.rd != '0);

    always_comb begin
        renamed.prs1 = dispatch.uses_rs1 ? spec_map[dispatch.rs1] : '0;
        renamed.prs2 = dispatch.uses_rs2 ? spec_map[dispatch.rs2] : '0;
        renamed.prd  = has_rd ? free_pick : '0;
        renamed.lprd = has_rd ? spec_map[dispatch.rd] : '0;
    end

    // speculative side, flush wins over accept and commit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RCU_ARCH_REGS; i++) begin
                spec_map[i] <= '0;
            end
            free_bits <= {{(`RCU_PHYS_REGS - 1){1'b1}}, 1'b0};
        end else if (trapped) begin
            for (int i = 0; i < `RCU_ARCH_REGS; i++) begin
                spec_map[i] <= comm_map[i];
            end
            // in-flight destinations come back here
            free_bits <= {~comm_busy[`RCU_PHYS_REGS-1:1], 1'b0};
        end else begin
            if (accept && has_rd) begin
                spec_map[dispatch.rd] <= free_pick;
                free_bits[free_pick] <= 1'b0;
            end
            if (commit.valid && (commit.lprd != '0)) begin
                free_bits[commit.lprd] <= 1'b1;
            end
        end
    end

    // committed side
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RCU_ARCH_REGS; i++) begin
                comm_map[i] <= '0;
            end
            comm_busy <= '0;
        end else if (commit.valid) begin
            if (commit.lprd != '0) begin
                comm_busy[commit.lprd] <= 1'b0;
            end
            // prd of 0 means no destination
            if (commit.prd != '0) begin
                comm_map[commit.rd] <= commit.prd;
                comm_busy[commit.prd] <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/issue_select.sv ====
// issue_select: physical ready bits, per-line issue state and oldest-ready selection
`timescale 1ns/10ps
`include "rcu_consts.svh"

module issue_select import rcu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  trapped,
    input  logic                  accept,
    input  logic [`RCU_ROB_W-1:0] accept_line,
    input  dispatch_t             dispatch,
    input  renamed_t              renamed,
    input  logic [`RCU_ROB_W-1:0] head_line,
    input  logic [`RCU_ROB_W-1:0] tail_line,
    input  logic                  fu_ready,
    input  wb_t                   writeback,
    output issue_t                issue
);

    // per-line operands, written on accept
    logic [`RCU_PC_W-1:0]   ent_pc   [`RCU_ROB_DEPTH];
    logic [`RCU_PHYS_W-1:0] ent_prs1 [`RCU_ROB_DEPTH];
    logic [`RCU_PHYS_W-1:0] ent_prs2 [`RCU_ROB_DEPTH];
    logic [`RCU_PHYS_W-1:0] ent_prd  [`RCU_ROB_DEPTH];

    // pending from accept until writeback
    logic [`RCU_ROB_DEPTH-1:0] pending;
    logic [`RCU_ROB_DEPTH-1:0] issued;
    logic [`RCU_PHYS_REGS-1:0] phys_ready;

    logic                  sel_found;
    logic [`RCU_ROB_W-1:0] sel_line;
    logic [`RCU_ROB_W-1:0] scan_line;
    logic                  scan_stop;
    logic                  fire;

    // walk from head, stop when the scan wraps onto tail
    always_comb begin
        sel_found = 1'b0;
        sel_line  = head_line;
        scan_line = head_line;
        scan_stop = 1'b0;
        for (int k = 0; k < `RCU_ROB_DEPTH; k++) begin
            scan_line = head_line + k[`RCU_ROB_W-1:0];
            if ((k != 0) && (scan_line == tail_line)) begin
                scan_stop = 1'b1;
            end
            if (!scan_stop && !sel_found && pending[scan_line] && !issued[scan_line]
                    && phys_ready[ent_prs1[scan_line]] && phys_ready[ent_prs2[scan_line]]) begin
                sel_found = 1'b1;
                sel_line  = scan_line;
            end
        end
    end

    always_comb begin
        issue.valid = sel_found && !trapped;
        issue.line  = sel_line;
        issue.pc    = ent_pc[sel_line];
        issue.prs1  = ent_prs1[sel_line];
        issue.prs2  = ent_prs2[sel_line];
        issue.prd   = ent_prd[sel_line];
    end

    assign fire = issue.valid && fu_ready;

    always_ff @(posedge clk) begin
        if (reset || trapped) begin
            pending <= '0;
            issued  <= '0;
        end else begin
            if (fire) begin
                issued[sel_line] <= 1'b1;
            end
            if (writeback.valid) begin
                pending[writeback.line] <= 1'b0;
            end
            if (accept) begin
                pending[accept_line] <= 1'b1;
                issued[accept_line]  <= 1'b0;
            end
        end
    end

    // p0 is never cleared, so it always reads ready
    always_ff @(posedge clk) begin
        if (reset || trapped) begin
            phys_ready <= '1;
        end else begin
            if (writeback.valid) begin
                phys_ready[writeback.prd] <= 1'b1;
            end
            if (accept && (renamed.prd != '0)) begin
                phys_ready[renamed.prd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_pc[accept_line]   <= dispatch.pc;
            ent_prs1[accept_line] <= renamed.prs1;
            ent_prs2[accept_line] <= renamed.prs2;
            ent_prd[accept_line]  <= renamed.prd;
        end
    end

endmodule

// ==== logic/rob_commit.sv ====
// rob_commit: reorder buffer lines, head and tail pointers, finish bits and in-order commit
`timescale 1ns/10ps
`include "rcu_consts.svh"

module rob_commit import rcu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  trapped,
    input  dispatch_t             dispatch,
    input  renamed_t              renamed,
    input  logic                  free_empty,
    input  wb_t                   writeback,
    output logic                  dispatch_ready,
    output logic                  accept,
    output logic [`RCU_ROB_W-1:0] head_line,
    output logic [`RCU_ROB_W-1:0] tail_line,
    output commit_t               commit
);

    logic [`RCU_ROB_W-1:0] head;
    logic [`RCU_ROB_W-1:0] tail;

    logic [`RCU_ROB_DEPTH-1:0] used;
    logic [`RCU_ROB_DEPTH-1:0] finished;

    // retire payload
    logic [`RCU_PC_W-1:0]   ent_pc   [`RCU_ROB_DEPTH];
    logic [`RCU_ARCH_W-1:0] ent_rd   [`RCU_ROB_DEPTH];
    logic [`RCU_PHYS_W-1:0] ent_prd  [`RCU_ROB_DEPTH];
    logic [`RCU_PHYS_W-1:0] ent_lprd [`RCU_ROB_DEPTH];

    logic do_commit;

    assign head_line = head;
    assign tail_line = tail;

    // room in the buffer and a register to hand out
    assign dispatch_ready = !used[tail] && !free_empty;
    assign accept = dispatch.valid && dispatch_ready && !trapped;

    // nothing retires on the flush edge
    assign do_commit = used[head] && finished[head] && !trapped;

    always_comb begin
        commit.valid = do_commit;
        commit.pc    = ent_pc[head];
        commit.rd    = ent_rd[head];
        commit.prd   = ent_prd[head];
        commit.lprd  = ent_lprd[head];
    end

    always_ff @(posedge clk) begin
        if (reset || trapped) begin
            head     <= '0;
            tail     <= '0;
            used     <= '0;
            finished <= '0;
        end else begin
            if (writeback.valid) begin
                finished[writeback.line] <= 1'b1;
            end
            if (do_commit) begin
                used[head]     <= 1'b0;
                finished[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (accept) begin
                used[tail]     <= 1'b1;
                finished[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
        end
    end

    // rd kept as 0 when the instruction writes nothing
    always_ff @(posedge clk) begin
        if (accept) begin
            ent_pc[tail]   <= dispatch.pc;
            ent_rd[tail]   <= dispatch.uses_rd ? dispatch.rd : '0;
            ent_prd[tail]  <= renamed.prd;
            ent_lprd[tail] <= renamed.lprd;
        end
    end

endmodule

// ==== logic/rcu_top.sv ====
// rcu_top: rename, issue and reorder stages of the rename and reorder unit
`timescale 1ns/10ps
`include "rcu_consts.svh"

module rcu_top import rcu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      trapped,
    input  logic      fu_ready,
    input  dispatch_t dispatch,
    input  wb_t       writeback,
    output logic      dispatch_ready,
    output issue_t    issue,
    output commit_t   commit
);

    logic                  accept;
    logic                  free_empty;
    logic [`RCU_ROB_W-1:0] head_line;
    logic [`RCU_ROB_W-1:0] tail_line;
    renamed_t              renamed;

    rename_map u_rename (
        .clk        (clk),
        .reset      (reset),
        .trapped    (trapped),
        .dispatch   (dispatch),
        .accept     (accept),
        .commit     (commit),
        .renamed    (renamed),
        .free_empty (free_empty)
    );

    // new entries land on the tail line
    issue_select u_issue (
        .clk         (clk),
        .reset       (reset),
        .trapped     (trapped),
        .accept      (accept),
        .accept_line (tail_line),
        .dispatch    (dispatch),
        .renamed     (renamed),
        .head_line   (head_line),
        .tail_line   (tail_line),
        .fu_ready    (fu_ready),
        .writeback   (writeback),
        .issue       (issue)
    );

    rob_commit u_rob (
        .clk            (clk),
        .reset          (reset),
        .trapped        (trapped),
        .dispatch       (dispatch),
        .renamed        (renamed),
        .free_empty     (free_empty),
        .writeback      (writeback),
        .dispatch_ready (dispatch_ready),
        .accept         (accept),
        .head_line      (head_line),
        .tail_line      (tail_line),
        .commit         (commit)
    );

endmodule

// ==== test/rcu_tb.sv ====
// stimulus table, function unit model, reference model and compare tasks for the rename unit
`timescale 1ns/10ps
`include "rcu_consts.svh"

module rcu_tb import rcu_pkg::*; ();

    // uses holds {rs1, rs2, rd}
    // hold is the fu_ready low time in cycles
    typedef struct packed {
        logic                   trap;
        logic [`RCU_ARCH_W-1:0] rd;
        logic [`RCU_ARCH_W-1:0] rs1;
        logic [`RCU_ARCH_W-1:0] rs2;
        logic [2:0]             uses;
        logic [7:0]             hold;
    } row_t;

    logic      clk;
    logic      reset;
    logic      trapped;
    logic      fu_ready;
    dispatch_t dispatch;
    wb_t       writeback;
    logic      dispatch_ready;
    issue_t    issue;
    commit_t   commit;

    row_t    stim_q[$];
    issue_t  iss_q[$];
    commit_t com_q[$];
    bit      done_q[$];
    // set once the entry's writeback edge has passed
    bit      fin_q[$];

    // reference state
    logic [`RCU_PHYS_W-1:0]    spec_map [`RCU_ARCH_REGS];
    logic [`RCU_PHYS_W-1:0]    comm_map [`RCU_ARCH_REGS];
    logic [`RCU_PHYS_REGS-1:0] free_set;
    logic [`RCU_PHYS_REGS-1:0] ready_set;
    logic [`RCU_ROB_W-1:0]     tail;

    // function unit with one slot per buffer line
    bit  fu_busy [`RCU_ROB_DEPTH];
    int  fu_wait [`RCU_ROB_DEPTH];
    wb_t fu_wb   [`RCU_ROB_DEPTH];

    dispatch_t   next_disp;
    logic        next_trap;
    logic        next_fu;
    wb_t         next_wb;
    logic        accepted;
    logic        last_ready;
    logic [31:0] lcg_state;
    int          row_idx;
    int          hold_left;
    int          cycles;
    int          limit;
    int          passes;
    int          fails;

    rcu_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .trapped        (trapped),
        .fu_ready       (fu_ready),
        .dispatch       (dispatch),
        .writeback      (writeback),
        .dispatch_ready (dispatch_ready),
        .issue          (issue),
        .commit         (commit)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`RCU_PHYS_W-1:0] lowest_free();
        for (int i = 1; i < `RCU_PHYS_REGS; i++) begin
            if (free_set[i]) begin
                return i[`RCU_PHYS_W-1:0];
            end
        end
        return '0;
    endfunction

    task automatic add_row(input logic trap, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [2:0] uses, input logic [7:0] hold);
        stim_q.push_back({trap, rd, rs1, rs2, uses, hold});
    endtask

    // fields shown as pc/rd/prd/lprd
    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: commit %h/%0d/%0d/%0d, expected %h/%0d/%0d/%0d",
                     $time, got.pc, got.rd, got.prd, got.lprd,
                     exp.pc, exp.rd, exp.prd, exp.lprd);
            fails++;
        end else begin
            $display("ok   commit pc %h rd %0d prd %0d lprd %0d",
                     got.pc, got.rd, got.prd, got.lprd);
            passes++;
        end
    endtask

    // fields shown as line/pc/prs1/prs2/prd
    task automatic check_issue(input issue_t got, input issue_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: issue %0d/%h/%0d/%0d/%0d, expected %0d/%h/%0d/%0d/%0d",
                     $time, got.line, got.pc, got.prs1, got.prs2, got.prd,
                     exp.line, exp.pc, exp.prs1, exp.prs2, exp.prd);
            fails++;
        end else begin
            $display("ok   issue pc %h prs1 %0d prs2 %0d prd %0d",
                     got.pc, got.prs1, got.prs2, got.prd);
            passes++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            fails++;
        end else begin
            $display("ok   %s = %b at %0d ns", name, got, $time);
            passes++;
        end
    endtask

    // predicts the coming rising edge from the values settled before it
    task automatic evaluate_edge();
        int      cand;
        int      l;
        logic    exp_rdy;
        logic    exp_com;
        logic    has_rd;
        issue_t  ni;
        commit_t nc;
        commit_t hc;
        cand = -1;
        accepted = 1'b0;
        next_wb = '0;
        exp_rdy = (com_q.size() < `RCU_ROB_DEPTH) && (free_set != '0);
        if ((exp_rdy !== last_ready) || (dispatch_ready !== exp_rdy)) begin
            check_bit("dispatch_ready", dispatch_ready, exp_rdy);
        end
        last_ready = exp_rdy;
        if (trapped) begin
            // only registers held by the committed map stay allocated
            free_set = '1;
            free_set[0] = 1'b0;
            for (int i = 0; i < `RCU_ARCH_REGS; i++) begin
                spec_map[i] = comm_map[i];
                free_set[comm_map[i]] = 1'b0;
            end
            ready_set = '1;
            iss_q.delete();
            com_q.delete();
            done_q.delete();
            fin_q.delete();
            tail = '0;
            for (int i = 0; i < `RCU_ROB_DEPTH; i++) begin
                fu_busy[i] = 1'b0;
            end
            return;
        end
        // head retires in the cycle after its writeback edge
        exp_com = 1'b0;
        if (com_q.size() != 0) begin
            exp_com = fin_q[0];
        end
        // oldest unissued entry with both sources ready
        for (int i = 0; i < iss_q.size(); i++) begin
            if ((cand < 0) && !done_q[i]
                    && ready_set[iss_q[i].prs1] && ready_set[iss_q[i].prs2]) begin
                cand = i;
            end
        end
        if (issue.valid !== (cand >= 0)) begin
            check_bit("issue.valid", issue.valid, cand >= 0);
        end else if (issue.valid && fu_ready) begin
            check_issue(issue, iss_q[cand]);
            done_q[cand] = 1'b1;
            l = iss_q[cand].line;
            fu_busy[l] = 1'b1;
            fu_wait[l] = int'(lcg_next() >> 30);
            fu_wb[l] = {1'b1, iss_q[cand].line, iss_q[cand].prd};
        end
        if (dispatch.valid && dispatch_ready) begin
            has_rd = dispatch.uses_rd && (dispatch.rd != '0);
            ni = {1'b1, tail, dispatch.pc, 18'd0};
            ni.prs1 = dispatch.uses_rs1 ? spec_map[dispatch.rs1] : '0;
            ni.prs2 = dispatch.uses_rs2 ? spec_map[dispatch.rs2] : '0;
            ni.prd = has_rd ? lowest_free() : '0;
            nc.valid = 1'b1;
            nc.pc = dispatch.pc;
            nc.rd = dispatch.uses_rd ? dispatch.rd : '0;
            nc.prd = ni.prd;
            nc.lprd = has_rd ? spec_map[dispatch.rd] : '0;
            if (has_rd) begin
                spec_map[dispatch.rd] = ni.prd;
                free_set[ni.prd] = 1'b0;
                ready_set[ni.prd] = 1'b0;
            end
            iss_q.push_back(ni);
            com_q.push_back(nc);
            done_q.push_back(1'b0);
            fin_q.push_back(1'b0);
            tail++;
            accepted = 1'b1;
        end
        if (writeback.valid) begin
            ready_set[writeback.prd] = 1'b1;
            for (int i = 0; i < iss_q.size(); i++) begin
                if (iss_q[i].line == writeback.line) begin
                    fin_q[i] = 1'b1;
                end
            end
        end
        if (commit.valid !== exp_com) begin
            check_bit("commit.valid", commit.valid, exp_com);
        end else if (commit.valid) begin
            hc = com_q.pop_front();
            void'(iss_q.pop_front());
            void'(done_q.pop_front());
            void'(fin_q.pop_front());
            check_commit(commit, hc);
            if (hc.lprd != '0) begin
                free_set[hc.lprd] = 1'b1;
            end
            if (hc.prd != '0) begin
                comm_map[hc.rd] = hc.prd;
            end
        end
        // one writeback per cycle for the lowest line whose delay ran out
        for (int i = 0; i < `RCU_ROB_DEPTH; i++) begin
            if (fu_busy[i] && (fu_wait[i] == 0) && !next_wb.valid) begin
                next_wb = fu_wb[i];
                fu_busy[i] = 1'b0;
            end else if (fu_busy[i] && (fu_wait[i] > 0)) begin
                fu_wait[i]--;
            end
        end
    endtask

    task automatic plan_inputs();
        row_t                 r;
        logic [`RCU_PC_W-1:0] pc;
        next_disp = '0;
        next_trap = 1'b0;
        if (row_idx < stim_q.size()) begin
            r = stim_q[row_idx];
            pc = row_idx * 4;
            next_trap = r.trap;
            if (!r.trap) begin
                next_disp = {1'b1, pc, r.rs1, r.rs2, r.rd, r.uses};
            end
        end
        next_fu = (hold_left == 0);
        if (hold_left > 0) begin
            hold_left--;
        end
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            if (com_q.size() != 0) begin
                $display("commit of pc %h never arrived within %0d cycles", com_q[0].pc, limit);
            end else begin
                $display("run did not finish within %0d cycles", limit);
            end
            $display("checks passed %0d, failed %0d", passes, fails + 1);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        trapped = 1'b0;
        fu_ready = 1'b1;
        dispatch = '0;
        writeback = '0;
        lcg_state = 32'h59f5d7ff;
        cycles = 0;
        passes = 0;
        fails = 0;
        row_idx = 0;
        hold_left = 0;
        for (int i = 0; i < `RCU_ARCH_REGS; i++) begin
            spec_map[i] = '0;
            comm_map[i] = '0;
        end
        free_set = {{(`RCU_PHYS_REGS - 1){1'b1}}, 1'b0};
        ready_set = '1;
        tail = '0;
        for (int i = 0; i < `RCU_ROB_DEPTH; i++) begin
            fu_busy[i] = 1'b0;
        end
        // trap, rd, rs1, rs2, uses {rs1, rs2, rd}, fu hold
        add_row(0, 5, 0, 0, 3'b001, 0);
        add_row(0, 6, 5, 0, 3'b101, 0);
        add_row(0, 7, 5, 6, 3'b111, 0);
        add_row(0, 5, 7, 0, 3'b101, 0);
        add_row(0, 0, 5, 7, 3'b110, 0);
        add_row(0, 0, 6, 0, 3'b101, 0);
        add_row(0, 8, 6, 5, 3'b111, 0);
        add_row(0, 9, 8, 0, 3'b101, 30);
        add_row(0, 10, 9, 0, 3'b101, 0);
        add_row(0, 11, 10, 7, 3'b111, 0);
        add_row(0, 12, 1, 2, 3'b111, 0);
        add_row(0, 13, 12, 0, 3'b101, 0);
        add_row(0, 14, 5, 9, 3'b111, 0);
        add_row(0, 15, 14, 0, 3'b101, 0);
        add_row(0, 16, 0, 0, 3'b001, 0);
        add_row(0, 17, 16, 15, 3'b111, 0);
        add_row(0, 3, 9, 0, 3'b101, 0);
        add_row(0, 4, 3, 10, 3'b111, 0);
        add_row(0, 20, 4, 0, 3'b101, 10);
        add_row(0, 21, 20, 0, 3'b101, 0);
        add_row(1, 0, 0, 0, 3'b000, 0);
        add_row(0, 13, 20, 21, 3'b111, 0);
        add_row(0, 22, 20, 0, 3'b101, 0);
        add_row(0, 5, 22, 9, 3'b111, 0);
        add_row(0, 6, 5, 5, 3'b111, 0);
        limit = stim_q.size() * 12 + 100;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        check_bit("issue.valid", issue.valid, 1'b0);
        check_bit("commit.valid", commit.valid, 1'b0);
        last_ready = 1'b1;
        next_wb = '0;
        plan_inputs();
        while ((row_idx < stim_q.size()) || (com_q.size() != 0)) begin
            @(posedge clk);
            dispatch <= next_disp;
            trapped <= next_trap;
            fu_ready <= next_fu;
            writeback <= next_wb;
            @(negedge clk);
            evaluate_edge();
            if ((row_idx < stim_q.size()) && (trapped || accepted)) begin
                row_idx++;
                if ((row_idx < stim_q.size()) && (stim_q[row_idx].hold != 0)) begin
                    hold_left = int'(stim_q[row_idx].hold);
                end
            end
            plan_inputs();
        end
        $display("checks passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
logic/rcu_pkg.sv
logic/rename_map.sv
logic/issue_select.sv
logic/rob_commit.sv
logic/rcu_top.sv
test/rcu_tb.sv

// ==== Bender.yml ====
package:
  name: rcu

sources:
  - include_dirs:
      - include
    files:
      - logic/rcu_pkg.sv
      - logic/rename_map.sv
      - logic/issue_select.sv
      - logic/rob_commit.sv
      - logic/rcu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/rcu_tb.sv
